//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = tb_global_controller
FILELIST  = verilog.f
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- bench/global_controller_assert.sv
// DRAM global controller checks
// one-hot bank strobes and read data timing
`include "dram_consts.svh"

module global_controller_assert (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic [`NUM_BANKS-1:0] o_bank_cmd_valid,
    input logic [`NUM_BANKS-1:0] o_bank_ren,
    input logic [`NUM_BANKS-1:0] i_ret_valid,
    input logic                  o_rd_valid
);

    // at most one bank gets a command
    a_cmd_onehot : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) $onehot0(o_bank_cmd_valid)
    ) else $error("more than one bank command valid");

    a_ren_onehot : assert property (
        @(posedge i_clk) disable iff (!i_rst_n) $onehot0(o_bank_ren)
    ) else $error("more than one bank read enable");

    // read data follows a return handshake by one cycle
    a_rd_after_hs : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_rd_valid |-> $past(|(i_ret_valid & o_bank_ren))
    ) else $error("read valid without a return handshake");

endmodule

//--- bench/tb_global_controller.sv
// DRAM global controller testbench
// random requests, bank models with stalls, a directed write
// flush and in-order read data checks
`include "dram_consts.svh"

module tb_global_controller
    import dram_pkg::*;
;

    localparam int ADDR_SIZE = 1 << $bits(dram_addr_t);
    localparam int TIMEOUT   = 2000;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_cmd_valid;
    dram_cmd_t             i_cmd;
    dram_data_t            i_wdata;
    logic                  o_ready;
    logic [`NUM_BANKS-1:0] i_bank_ready;
    logic [`NUM_BANKS-1:0] o_bank_cmd_valid;
    dram_cmd_t             o_bank_cmd;
    dram_data_t            o_bank_wdata;
    logic [`NUM_BANKS-1:0] i_ret_valid;
    dram_data_t            i_ret_data [`NUM_BANKS];
    logic [`NUM_BANKS-1:0] o_bank_ren;
    logic                  o_rd_valid;
    dram_data_t            o_rd_data;

    int         error_count;
    logic       stall_banks;
    dram_data_t exp_q [$];
    dram_data_t ret_q [`NUM_BANKS][$];
    dram_data_t bank_mem [ADDR_SIZE];
    logic       bank_written [ADDR_SIZE];
    dram_data_t ref_mem [ADDR_SIZE];
    logic       ref_written [ADDR_SIZE];

    global_controller uut (.*);

    bind global_controller global_controller_assert u_assert (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .o_bank_cmd_valid(o_bank_cmd_valid),
        .o_bank_ren(o_bank_ren), .i_ret_valid(i_ret_valid), .o_rd_valid(o_rd_valid)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
        begin
            #10 i_clk = ~i_clk;
        end
    end

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_data(input string name, input dram_data_t got, input dram_data_t exp);
        if (got !== exp)
        begin
            error_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bank(input string name, input bank_t got, input bank_t exp);
        if (got !== exp)
        begin
            error_count++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            error_count++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // expected read value from a program-order memory image
    function automatic dram_data_t ref_access(input dram_cmd_t cmd, input dram_data_t wdata);
        if (cmd.op == OP_WRITE)
        begin
            ref_mem[cmd.addr]     = wdata;
            ref_written[cmd.addr] = 1'b1;
            return wdata;
        end
        return ref_written[cmd.addr] ? ref_mem[cmd.addr] : dram_data_t'(cmd.addr);
    endfunction

    task automatic end_run();
        $display("errors: %0d, reads left unchecked: %0d", error_count, exp_q.size());
        if (error_count == 0 && exp_q.size() == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("timeout at %0t while waiting for %s", $time, what);
        end_run();
    endtask

    // holds the request until the controller takes it
    task automatic send_req(input dram_cmd_t cmd, input dram_data_t wdata);
        int waited;
        dram_data_t exp;
        i_cmd_valid <= 1'b1;
        i_cmd       <= cmd;
        i_wdata     <= wdata;
        waited = 0;
        @(posedge i_clk);
        while (!o_ready)
        begin
            waited++;
            if (waited > TIMEOUT)
            begin
                report_timeout("request acceptance");
            end
            @(posedge i_clk);
        end
        exp = ref_access(cmd, wdata);
        if (cmd.op == OP_READ)
        begin
            exp_q.push_back(exp);
        end
    endtask

    task automatic go_idle();
        i_cmd_valid <= 1'b0;
        i_cmd       <= '{op: OP_WRITE, addr: '0};
        @(posedge i_clk);
    endtask

    ////////////////////
    // bank models
    ////////////////////
    always @(posedge i_clk)
    begin
        if (i_rst_n)
        begin
            for (int b = 0; b < `NUM_BANKS; b++)
            begin
                if (i_ret_valid[b] && o_bank_ren[b])
                begin
                    void'(ret_q[b].pop_front());
                end
                if (o_bank_cmd_valid[b])
                begin
                    if (o_bank_cmd.op == OP_WRITE)
                    begin
                        bank_mem[o_bank_cmd.addr]     = o_bank_wdata;
                        bank_written[o_bank_cmd.addr] = 1'b1;
                    end
                    else if (bank_written[o_bank_cmd.addr])
                    begin
                        ret_q[b].push_back(bank_mem[o_bank_cmd.addr]);
                    end
                    else
                    begin
                        ret_q[b].push_back(dram_data_t'(o_bank_cmd.addr));
                    end
                end
                i_bank_ready[b] <= !stall_banks && ($urandom % 4 != 0);
                i_ret_valid[b]  <= (ret_q[b].size() > 0) && ($urandom % 3 != 0);
                i_ret_data[b]   <= (ret_q[b].size() > 0) ? ret_q[b][0] : '0;
            end
        end
    end

    // bank strobe must match the bus address
    always @(posedge i_clk)
    begin
        if (i_rst_n && (o_bank_cmd_valid != '0))
        begin
            for (int b = 0; b < `NUM_BANKS; b++)
            begin
                if (o_bank_cmd_valid[b])
                begin
                    check_bank("o_bank_cmd_valid bank", bank_t'(b), o_bank_cmd.addr.bank);
                end
            end
        end
    end

    // read data against the expected queue
    always @(posedge i_clk)
    begin
        if (i_rst_n && o_rd_valid)
        begin
            if (exp_q.size() == 0)
            begin
                error_count++;
                $display("read data at %0t with no read outstanding", $time);
            end
            else
            begin
                check_data("o_rd_data", o_rd_data, exp_q.pop_front());
            end
        end
    end

    initial
    begin
        dram_addr_t wr_addr [$];
        dram_cmd_t  cmd;
        int         waited;
        logic       flush_expected;
        void'($urandom(32'hbc16d4d3));
        error_count  = 0;
        stall_banks  = 1'b0;
        i_rst_n      = 1'b0;
        i_cmd_valid  = 1'b0;
        i_cmd        = '{op: OP_WRITE, addr: '0};
        i_wdata      = '0;
        i_bank_ready = '0;
        i_ret_valid  = '0;
        for (int b = 0; b < `NUM_BANKS; b++)
        begin
            i_ret_data[b] = '0;
        end
        // nothing written yet in the bank models or the reference image
        for (int a = 0; a < ADDR_SIZE; a++)
        begin
            bank_written[a] = 1'b0;
            ref_written[a]  = 1'b0;
        end
        repeat (3) @(posedge i_clk);
        check_level("o_bank_cmd_valid", |o_bank_cmd_valid, 1'b0);
        check_level("o_bank_ren", |o_bank_ren, 1'b0);
        check_level("o_rd_valid", o_rd_valid, 1'b0);
        check_level("o_ready", o_ready, 1'b1);
        i_rst_n <= 1'b1;

        ////////////////////
        // directed write flush
        ////////////////////
        stall_banks <= 1'b1;
        repeat (3) @(posedge i_clk);
        for (int i = 0; i < 10; i++)
        begin
            cmd = '{op: OP_WRITE, addr: dram_addr_t'(i * 5 + 1)};
            wr_addr.push_back(cmd.addr);
            send_req(cmd, $urandom);
        end
        // the first eight writes fill the scheduled queue
        cmd = '{op: OP_READ, addr: wr_addr[9]};
        flush_expected = 1'b0;
        for (int i = 8; i < wr_addr.size(); i++)
        begin
            if (wr_addr[i] == cmd.addr)
            begin
                flush_expected = 1'b1;
            end
        end
        send_req(cmd, '0);
        go_idle();
        if (flush_expected)
        begin
            check_level("o_ready", o_ready, 1'b0);
        end
        stall_banks <= 1'b0;
        waited = 0;
        while (!o_ready)
        begin
            waited++;
            if (waited > TIMEOUT)
            begin
                report_timeout("o_ready after write flush");
            end
            @(posedge i_clk);
        end

        ////////////////////
        // random traffic
        ////////////////////
        for (int n = 0; n < 400; n++)
        begin
            if ($urandom % 4 == 0)
            begin
                go_idle();
            end
            else
            begin
                cmd.op   = ($urandom % 2 == 0) ? OP_READ : OP_WRITE;
                cmd.addr = '{row: 4'($urandom % 2), col: 3'($urandom % 2),
                             bank: bank_t'($urandom)};
                send_req(cmd, $urandom);
            end
        end
        go_idle();

        waited = 0;
        while (exp_q.size() != 0)
        begin
            waited++;
            if (waited > TIMEOUT)
            begin
                report_timeout("outstanding read data");
            end
            @(posedge i_clk);
        end
        repeat (20) @(posedge i_clk);
        end_run();
    end

endmodule

//--- hdl/bank_dispatch.sv
// Bank dispatch
// scheduled queue in front of the banks; the head leaves when its
// bank is ready and is driven on the shared command bus one cycle
// later, popped reads are logged for in-order return
`include "dram_consts.svh"

module bank_dispatch
    import dram_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_sched_push,
    input  sched_entry_t          i_sched_entry,
    output logic                  o_sched_full,
    output logic                  o_sched_pop,
    input  logic [`NUM_BANKS-1:0] i_bank_ready,
    output logic [`NUM_BANKS-1:0] o_bank_cmd_valid,
    output dram_cmd_t             o_bank_cmd,
    output dram_data_t            o_bank_wdata,
    output logic                  o_order_push,
    output bank_t                 o_order_bank
);

    sched_entry_t          head;
    logic                  sched_empty;
    bank_t                 head_bank;
    logic [`NUM_BANKS-1:0] valid_next;

    sync_fifo #(
        .WIDTH($bits(sched_entry_t)),
        .DEPTH(`REQ_DEPTH)
    ) u_sched_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_sched_push),
        .i_pop   (o_sched_pop),
        .i_data  (i_sched_entry),
        .o_data  (head),
        .o_empty (sched_empty),
        .o_full  (o_sched_full)
    );

    assign head_bank = head.cmd.addr.bank;

    // a stalled bank blocks everything behind its head entry
    assign o_sched_pop = !sched_empty && i_bank_ready[head_bank];

    always_comb
    begin
        for (int b = 0; b < `NUM_BANKS; b++)
        begin
            valid_next[b] = o_sched_pop && (head_bank == bank_t'(b));
        end
    end

    // read order log
    assign o_order_push = o_sched_pop && (head.cmd.op == OP_READ);
    assign o_order_bank = head_bank;

    ////////////////////
    // command bus
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_bank_cmd_valid <= '0;
        end
        else
        begin
            o_bank_cmd_valid <= valid_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_sched_pop)
        begin
            o_bank_cmd   <= head.cmd;
            o_bank_wdata <= head.data;
        end
    end

endmodule

//--- hdl/dram_consts.svh
// DRAM global controller constants
// address split, data word width, bank count and queue sizes
`ifndef DRAM_CONSTS_SVH
`define DRAM_CONSTS_SVH

// address fields
`define ROW_BITS 4
`define COL_BITS 3
`define BANK_BITS 2
`define NUM_BANKS 4

// data word
`define DATA_BITS 32

// queue depths
`define REQ_DEPTH 8
`define ORDER_DEPTH 32

`endif

//--- hdl/dram_pkg.sv
// DRAM global controller types
// opcode, address, command and scheduled entry formats
`include "dram_consts.svh"

package dram_pkg;

    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

    typedef logic [`BANK_BITS-1:0] bank_t;

    typedef struct packed
    {
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] col;
        bank_t                bank;
    } dram_addr_t;

    // request port, queues and bank command bus
    typedef struct packed
    {
        op_t        op;
        dram_addr_t addr;
    } dram_cmd_t;

    typedef logic [`DATA_BITS-1:0] dram_data_t;

    // unit of the scheduled stream
    typedef struct packed
    {
        dram_cmd_t  cmd;
        dram_data_t data;
    } sched_entry_t;

endpackage

//--- hdl/global_controller.sv
// DRAM global controller
// one request port in front of four bank controllers, with read
// priority, RAW write flush and in-order read return
`include "dram_consts.svh"

module global_controller
    import dram_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    // request port
    input  logic                  i_cmd_valid,
    input  dram_cmd_t             i_cmd,
    input  dram_data_t            i_wdata,
    output logic                  o_ready,
    // bank command bus
    input  logic [`NUM_BANKS-1:0] i_bank_ready,
    output logic [`NUM_BANKS-1:0] o_bank_cmd_valid,
    output dram_cmd_t             o_bank_cmd,
    output dram_data_t            o_bank_wdata,
    // bank return
    input  logic [`NUM_BANKS-1:0] i_ret_valid,
    input  dram_data_t            i_ret_data [`NUM_BANKS],
    output logic [`NUM_BANKS-1:0] o_bank_ren,
    // read port
    output logic                  o_rd_valid,
    output dram_data_t            o_rd_data
);

    sched_entry_t wq_entry;
    sched_entry_t wq_head;
    sched_entry_t sched_entry;
    logic         wq_push;
    logic         wq_pop;
    logic         wq_empty;
    logic         wq_full;
    logic         flush;
    logic         sched_push;
    logic         sched_pop;
    logic         sched_full;
    logic         order_push;
    bank_t        order_bank;

    assign wq_entry = '{cmd: i_cmd, data: i_wdata};

    request_scheduler u_sched (
        .i_clk, .i_rst_n, .i_cmd_valid, .i_cmd, .i_wdata, .o_ready,
        .i_wq_head     (wq_head),
        .i_wq_empty    (wq_empty),
        .i_wq_full     (wq_full),
        .i_flush       (flush),
        .o_wq_push     (wq_push),
        .o_wq_pop      (wq_pop),
        .i_sched_full  (sched_full),
        .i_sched_pop   (sched_pop),
        .o_sched_push  (sched_push),
        .o_sched_entry (sched_entry)
    );

    // probe sees the request port command directly
    write_queue u_wq (
        .i_clk, .i_rst_n,
        .i_push      (wq_push),
        .i_pop       (wq_pop),
        .i_entry     (wq_entry),
        .i_probe_cmd (i_cmd),
        .o_head      (wq_head),
        .o_empty     (wq_empty),
        .o_full      (wq_full),
        .o_flush     (flush)
    );

    bank_dispatch u_dispatch (
        .i_clk, .i_rst_n, .i_bank_ready, .o_bank_cmd_valid, .o_bank_cmd, .o_bank_wdata,
        .i_sched_push  (sched_push),
        .i_sched_entry (sched_entry),
        .o_sched_full  (sched_full),
        .o_sched_pop   (sched_pop),
        .o_order_push  (order_push),
        .o_order_bank  (order_bank)
    );

    read_return u_return (
        .i_clk, .i_rst_n, .i_ret_valid, .i_ret_data, .o_bank_ren, .o_rd_valid, .o_rd_data,
        .i_order_push (order_push),
        .i_order_bank (order_bank)
    );

endmodule

//--- hdl/read_return.sv
// Read return
// enables the bank that holds the oldest outstanding read and
// registers its word onto the read data port
`include "dram_consts.svh"

module read_return
    import dram_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_order_push,
    input  bank_t                 i_order_bank,
    input  logic [`NUM_BANKS-1:0] i_ret_valid,
    input  dram_data_t            i_ret_data [`NUM_BANKS],
    output logic [`NUM_BANKS-1:0] o_bank_ren,
    output logic                  o_rd_valid,
    output dram_data_t            o_rd_data
);

    bank_t head_bank;
    logic  order_empty;
    logic  ret_hs;

    sync_fifo #(
        .WIDTH($bits(bank_t)),
        .DEPTH(`ORDER_DEPTH)
    ) u_order_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_order_push),
        .i_pop   (ret_hs),
        .i_data  (i_order_bank),
        .o_data  (head_bank),
        .o_empty (order_empty),
        .o_full  ()
    );

    // one-hot enable for the head bank only
    always_comb
    begin
        for (int b = 0; b < `NUM_BANKS; b++)
        begin
            o_bank_ren[b] = !order_empty && (head_bank == bank_t'(b));
        end
    end

    assign ret_hs = |(i_ret_valid & o_bank_ren);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_rd_valid <= 1'b0;
        end
        else
        begin
            o_rd_valid <= ret_hs;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (ret_hs)
        begin
            o_rd_data <= i_ret_data[head_bank];
        end
    end

endmodule

//--- hdl/request_scheduler.sv
// Request scheduler
// accepts host requests into the read or write queue and picks
// the next entry for the scheduled stream, reads first unless a
// write flush is running
`include "dram_consts.svh"

module request_scheduler
    import dram_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_cmd_valid,
    input  dram_cmd_t    i_cmd,
    input  dram_data_t   i_wdata,
    output logic         o_ready,
    input  sched_entry_t i_wq_head,
    input  logic         i_wq_empty,
    input  logic         i_wq_full,
    input  logic         i_flush,
    output logic         o_wq_push,
    output logic         o_wq_pop,
    input  logic         i_sched_full,
    input  logic         i_sched_pop,
    output logic         o_sched_push,
    output sched_entry_t o_sched_entry
);

    localparam int CNT_W = $clog2(`REQ_DEPTH + 1);

    sched_entry_t     req_entry;
    sched_entry_t     rq_head;
    logic             rq_push;
    logic             rq_pop;
    logic             rq_empty;
    logic             rq_full;
    logic [CNT_W-1:0] rq_count;
    logic             accept;
    logic             rd_acc_q;
    logic             hold_q;
    logic             hold_tail;
    logic             pick_write;

    ////////////////////
    // acceptance
    ////////////////////
    assign o_ready   = !rq_full && !i_wq_full && !i_flush;
    assign accept    = i_cmd_valid && o_ready;
    assign rq_push   = accept && (i_cmd.op == OP_READ);
    assign o_wq_push = accept && (i_cmd.op == OP_WRITE);
    assign req_entry = '{cmd: i_cmd, data: i_wdata};

    // reads keep the request word too, banks ignore it
    sync_fifo #(
        .WIDTH($bits(sched_entry_t)),
        .DEPTH(`REQ_DEPTH)
    ) u_read_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (rq_push),
        .i_pop   (rq_pop),
        .i_data  (req_entry),
        .o_data  (rq_head),
        .o_empty (rq_empty),
        .o_full  (rq_full)
    );

    ////////////////////
    // selection
    ////////////////////
    // the read that caused the flush sits at the read queue tail;
    // older reads ahead of it still go before the queued writes
    assign hold_tail  = i_flush && (hold_q || rd_acc_q);
    assign pick_write = !i_wq_empty
                        && (rq_empty || (hold_tail && (rq_count == CNT_W'(1))));

    assign o_sched_push  = (!rq_empty || !i_wq_empty) && (!i_sched_full || i_sched_pop);
    assign o_wq_pop      = o_sched_push && pick_write;
    assign rq_pop        = o_sched_push && !pick_write;
    assign o_sched_entry = pick_write ? i_wq_head : rq_head;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rq_count <= '0;
            rd_acc_q <= 1'b0;
            hold_q   <= 1'b0;
        end
        else
        begin
            rq_count <= rq_count + CNT_W'(rq_push) - CNT_W'(rq_pop);
            rd_acc_q <= rq_push;
            hold_q   <= hold_tail;
        end
    end

endmodule

//--- hdl/sync_fifo.sv
// Synchronous FIFO
// single-clock circular buffer with a fill count,
// head word shown on o_data before it is popped
module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_data  = mem[rd_ptr];

    // full buffer still takes a push when the head leaves in the same cycle
    assign do_pop  = i_pop && !o_empty;
    assign do_push = i_push && (!o_full || do_pop);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

//--- hdl/write_queue.sv
// Write queue
// holds write commands with their data, compares an incoming
// read against every queued write address and raises the flush
// level on a hit until the queue has drained
`include "dram_consts.svh"

module write_queue
    import dram_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_push,
    input  logic         i_pop,
    input  sched_entry_t i_entry,
    input  dram_cmd_t    i_probe_cmd,
    output sched_entry_t o_head,
    output logic         o_empty,
    output logic         o_full,
    output logic         o_flush
);

    localparam int PTR_W = $clog2(`REQ_DEPTH);
    localparam int CNT_W = $clog2(`REQ_DEPTH + 1);

    sched_entry_t          slot [`REQ_DEPTH];
    logic [`REQ_DEPTH-1:0] slot_valid;
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [CNT_W-1:0]      count_next;
    logic                  do_push;
    logic                  do_pop;
    logic                  raw_hit;

    assign o_empty    = (count == '0);
    assign o_full     = (count == CNT_W'(`REQ_DEPTH));
    assign o_head     = slot[rd_ptr];
    assign do_push    = i_push && !o_full;
    assign do_pop     = i_pop && !o_empty;
    assign count_next = count + CNT_W'(do_push) - CNT_W'(do_pop);

    ////////////////////
    // RAW detection
    ////////////////////
    always_comb
    begin
        raw_hit = 1'b0;
        if (i_probe_cmd.op == OP_READ)
        begin
            for (int i = 0; i < `REQ_DEPTH; i++)
            begin
                if (slot_valid[i] && (slot[i].cmd.addr == i_probe_cmd.addr))
                begin
                    raw_hit = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            slot_valid <= '0;
            o_flush    <= 1'b0;
        end
        else
        begin
            if (do_push)
            begin
                slot_valid[wr_ptr] <= 1'b1;
                wr_ptr <= (wr_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                slot_valid[rd_ptr] <= 1'b0;
                rd_ptr <= (rd_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // flush ends once the last write has left
            if (count_next == '0)
            begin
                o_flush <= 1'b0;
            end
            else if (raw_hit)
            begin
                o_flush <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
        begin
            slot[wr_ptr] <= i_entry;
        end
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/dram_pkg.sv
hdl/sync_fifo.sv
hdl/write_queue.sv
hdl/request_scheduler.sv
hdl/bank_dispatch.sv
hdl/read_return.sv
hdl/global_controller.sv
bench/global_controller_assert.sv
bench/tb_global_controller.sv
